// File: build.sh
#!/bin/sh
# Compile the core and its testbench with Verilator, then run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
    -f sources.f \
    --top-module cpuTop_tb \
    -Mdir obj_dir \
    -o cpuTop_sim

output=$(./obj_dir/cpuTop_sim 2>&1) || true
echo "$output"
echo "$output" | grep -q "all tests passed"

// File: hdl/aluUnit.sv
`timescale 1ns/1ns

module aluUnit
    import cpuIsaPkg::*, cpuCorePkg::*;
(
    input  aluReqT aluReq,
    output aluResT aluRes
);

    logic [16:0] sum;       // Carry or borrow lands in bit 8 or 16
    logic        cin;
    logic        isSub;
    logic        isArith;
    logic        aMsb;
    logic        bMsb;
    logic        rMsb;
    wordT        result;
    flagsT       flagsOut;

    assign cin     = (aluReq.op == ALU_ADC || aluReq.op == ALU_SBB) && aluReq.flags[FLAG_CF];
    assign isSub   = aluReq.op inside {ALU_SBB, ALU_SUB, ALU_CMP};
    assign isArith = isSub || aluReq.op inside {ALU_ADD, ALU_ADC};

    always_comb begin
        unique case (aluReq.op)
            ALU_ADD, ALU_ADC:
                sum = {1'b0, aluReq.op1} + {1'b0, aluReq.op2} + {16'h0000, cin};
            ALU_SBB, ALU_SUB, ALU_CMP:
                sum = {1'b0, aluReq.op1} - {1'b0, aluReq.op2} - {16'h0000, cin};
            ALU_OR:  sum = {1'b0, aluReq.op1 | aluReq.op2};
            ALU_AND: sum = {1'b0, aluReq.op1 & aluReq.op2};
            ALU_XOR: sum = {1'b0, aluReq.op1 ^ aluReq.op2};
        endcase
    end

    // Byte ops keep zeros above bit 7
    assign result = aluReq.wide ? sum[15:0] : {8'h00, sum[7:0]};

    assign aMsb = aluReq.wide ? aluReq.op1[15] : aluReq.op1[7];
    assign bMsb = aluReq.wide ? aluReq.op2[15] : aluReq.op2[7];
    assign rMsb = aluReq.wide ? result[15] : result[7];

    // ------------------------------
    // Status flags
    always_comb begin
        flagsOut           = aluReq.flags;
        flagsOut[FLAG_ONE] = 1'b1;
        flagsOut[FLAG_CF]  = isArith && (aluReq.wide ? sum[16] : sum[8]);
        flagsOut[FLAG_PF]  = ~^result[7:0];   // Even parity of low byte
        flagsOut[FLAG_AF]  = isArith && (aluReq.op1[4] ^ aluReq.op2[4] ^ sum[4]);
        flagsOut[FLAG_ZF]  = result == '0;
        flagsOut[FLAG_SF]  = rMsb;

        // Signed overflow when the result sign leaves op1's sign
        if (!isArith)
            flagsOut[FLAG_OF] = 1'b0;
        else if (isSub)
            flagsOut[FLAG_OF] = (aMsb ^ bMsb) & (aMsb ^ rMsb);
        else
            flagsOut[FLAG_OF] = ~(aMsb ^ bMsb) & (aMsb ^ rMsb);
    end

    assign aluRes = '{result: result, flags: flagsOut};

endmodule

// File: hdl/cpuCorePkg.sv
package cpuCorePkg;

    import cpuIsaPkg::*;

    // Sequencer phases
    typedef enum logic {
        FETCH,
        EXEC
    } seqStateT;

    typedef struct packed {
        logic    en;
        regCodeT code;
        logic    wide;     // 0 selects the byte view
        wordT    data;
    } regWriteT;

    typedef struct packed {
        aluOpT op;
        logic  wide;
        wordT  op1;
        wordT  op2;
        flagsT flags;      // Incoming FLAGS, CF feeds ADC/SBB
    } aluReqT;

    typedef struct packed {
        wordT  result;
        flagsT flags;
    } aluResT;

    typedef struct packed {
        wordT addr;
        wordT data;
        logic wide;
    } portWriteT;

endpackage

// File: hdl/cpuIsaPkg.sv
`include "cpu_config.svh"

package cpuIsaPkg;

    typedef logic [`WORD_W-1:0]     wordT;      // Registers, IP, results
    typedef logic [`BYTE_W-1:0]     byteT;      // Code bus byte
    typedef logic [`REG_CODE_W-1:0] regCodeT;
    typedef logic [`FLAGS_W-1:0]    flagsT;

    // Opcode bits 5:3 of the ALU group
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_OR,
        ALU_ADC,
        ALU_SBB,
        ALU_AND,
        ALU_SUB,
        ALU_XOR,
        ALU_CMP
    } aluOpT;

    // Jcc opcode bits 3:1, bit 0 inverts
    typedef enum logic [2:0] {
        COND_O,
        COND_C,
        COND_Z,
        COND_CZ,
        COND_S,
        COND_P,
        COND_SXO,   // SF != OF
        COND_SXOZ   // SF != OF or ZF
    } condT;

    // ------------------------------
    // Flag bit positions
    localparam int FLAG_CF  = 0;
    localparam int FLAG_ONE = 1;   // Always reads 1
    localparam int FLAG_PF  = 2;
    localparam int FLAG_AF  = 4;
    localparam int FLAG_ZF  = 6;
    localparam int FLAG_SF  = 7;
    localparam int FLAG_OF  = 11;

    localparam flagsT FLAGS_RESET = 12'h002;

    // Register codes used directly by the decoder
    localparam regCodeT REG_AX = 3'd0;
    localparam regCodeT REG_DX = 3'd2;

endpackage

// File: hdl/cpuTop.sv
`timescale 1ns/1ns

module cpuTop
    import cpuIsaPkg::*, cpuCorePkg::*;
(
    input  logic      clk25,
    input  logic      reset,
    output wordT      codeAddr,
    input  byteT      codeData,
    output portWriteT portOut,
    output logic      portClk,
    input  logic      portCredit
);

    regCodeT   readSel;
    logic      readWide;
    wordT      readData;
    regWriteT  regWrite;
    aluReqT    aluReq;
    aluResT    aluRes;
    logic      portReq;
    logic      portAccept;
    portWriteT portReqData;

    sequencer sequencerInst (
        .clk25, .reset, .codeAddr, .codeData,
        .readSel, .readWide, .readData, .regWrite,
        .aluReq, .aluRes,
        .portReq, .portReqData, .portAccept
    );

    registerFile registerFileInst (.clk25, .reset, .readSel, .readWide, .readData, .regWrite);

    aluUnit aluUnitInst (.aluReq, .aluRes);

    // Credit-based output port
    portWriter portWriterInst (
        .clk25, .reset, .portReq, .portReqData, .portAccept,
        .portCredit, .portOut, .portClk
    );

endmodule

// File: hdl/portWriter.sv
`timescale 1ns/1ns
`include "cpu_config.svh"

module portWriter
    import cpuCorePkg::*;
(
    input  logic      clk25,
    input  logic      reset,
    input  logic      portReq,
    input  portWriteT portReqData,
    output logic      portAccept,
    input  logic      portCredit,
    output portWriteT portOut,
    output logic      portClk
);

    logic [`CREDIT_W-1:0] credits;

    assign portAccept = portReq && credits != '0;

    always_ff @(posedge clk25) begin
        if (reset) begin
            credits <= `CREDIT_W'(`PORT_CREDITS);
            portClk <= 1'b0;
            portOut <= '0;
        end else begin
            portClk <= portAccept;      // Strobe follows the accept
            if (portAccept)
                portOut <= '{addr: portReqData.addr,
                             data: portReqData.wide ? portReqData.data
                                                    : {8'h00, portReqData.data[7:0]},
                             wide: portReqData.wide};

            // Spend and return in one cycle cancel out
            if (portAccept && !portCredit)
                credits <= credits - 1'b1;
            else if (!portAccept && portCredit && credits < `CREDIT_W'(`PORT_CREDITS))
                credits <= credits + 1'b1;
        end
    end

endmodule

// File: hdl/registerFile.sv
`timescale 1ns/1ns
`include "cpu_config.svh"

module registerFile
    import cpuIsaPkg::*, cpuCorePkg::*;
(
    input  logic     clk25,
    input  logic     reset,
    input  regCodeT  readSel,
    input  logic     readWide,
    output wordT     readData,
    input  regWriteT regWrite
);

    wordT regs [8];     // AX CX DX BX SP BP SI DI

    // Byte codes 4..7 map to the high halves of AX..BX
    always_comb begin
        if (readWide)
            readData = regs[readSel];
        else if (readSel[2])
            readData = {8'h00, regs[{1'b0, readSel[1:0]}][`WORD_W-1:`BYTE_W]};
        else
            readData = {8'h00, regs[readSel][`BYTE_W-1:0]};
    end

    always_ff @(posedge clk25) begin
        if (reset) begin
            for (int k = 0; k < 8; k++)
                regs[k] <= '0;
        end else if (regWrite.en) begin
            if (regWrite.wide)
                regs[regWrite.code] <= regWrite.data;
            else if (regWrite.code[2])  // AH CH DH BH
                regs[{1'b0, regWrite.code[1:0]}][`WORD_W-1:`BYTE_W] <=
                    regWrite.data[`BYTE_W-1:0];
            else
                regs[regWrite.code][`BYTE_W-1:0] <= regWrite.data[`BYTE_W-1:0];
        end
    end

endmodule

// File: hdl/sequencer.sv
`timescale 1ns/1ns
`include "cpu_config.svh"

module sequencer
    import cpuIsaPkg::*, cpuCorePkg::*;
(
    input  logic      clk25,
    input  logic      reset,
    output wordT      codeAddr,
    input  byteT      codeData,
    output regCodeT   readSel,
    output logic      readWide,
    input  wordT      readData,
    output regWriteT  regWrite,
    output aluReqT    aluReq,
    input  aluResT    aluRes,
    output logic      portReq,
    output portWriteT portReqData,
    input  logic      portAccept
);

    seqStateT state, stateNext;
    wordT     ip, ipNext;
    flagsT    flags, flagsNext;
    logic     step, stepNext;           // Immediate byte index in EXEC
    byteT     opcode;
    byteT     immLow, immLowNext;       // Low byte of an imm16
    wordT     portAddr, portAddrNext;
    wordT     immWord;
    wordT     disp;
    condT     cond;
    logic     condHit;

    assign codeAddr = ip;               // No data memory, code always at IP
    assign immWord  = step ? {codeData, immLow} : {8'h00, codeData};
    assign disp     = {{8{codeData[7]}}, codeData};
    assign cond     = condT'(opcode[3:1]);

    always_comb begin
        unique case (cond)
            COND_O:    condHit = flags[FLAG_OF];
            COND_C:    condHit = flags[FLAG_CF];
            COND_Z:    condHit = flags[FLAG_ZF];
            COND_CZ:   condHit = flags[FLAG_CF] | flags[FLAG_ZF];
            COND_S:    condHit = flags[FLAG_SF];
            COND_P:    condHit = flags[FLAG_PF];
            COND_SXO:  condHit = flags[FLAG_SF] ^ flags[FLAG_OF];
            COND_SXOZ: condHit = (flags[FLAG_SF] ^ flags[FLAG_OF]) | flags[FLAG_ZF];
        endcase
    end

    // ------------------------------
    // Decode and next state
    always_comb begin
        stateNext    = state;
        ipNext       = ip;
        flagsNext    = flags;
        stepNext     = step;
        immLowNext   = immLow;
        portAddrNext = portAddr;
        readSel      = REG_AX;
        readWide     = 1'b1;
        portReq      = 1'b0;
        portReqData  = '{addr: portAddr, data: readData, wide: opcode[0]};
        aluReq       = '{op: aluOpT'(opcode[5:3]), wide: opcode[0], op1: readData,
                         op2: immWord, flags: flags};
        regWrite     = '{en: 1'b0, code: opcode[2:0], wide: opcode[3], data: immWord};

        unique case (state)
            FETCH: begin
                ipNext   = ip + 16'd1;
                stepNext = 1'b0;
                casez (codeData)
                    8'hF5:        flagsNext[FLAG_CF] = ~flags[FLAG_CF];  // CMC
                    8'b1111_100?: flagsNext[FLAG_CF] = codeData[0];      // CLC/STC
                    8'b1011_????, 8'b00??_?10?, 8'b0100_????, 8'b0111_????,
                    8'hEB, 8'b1110_?11?:
                        stateNext = EXEC;
                    default: ;   // NOP and anything unsupported
                endcase
            end

            EXEC: casez (opcode)
                8'b1011_????: begin     // MOV r, imm
                    ipNext = ip + 16'd1;
                    if (opcode[3] && !step) begin
                        immLowNext = codeData;
                        stepNext   = 1'b1;
                    end else begin
                        regWrite.en = 1'b1;
                        stateNext   = FETCH;
                    end
                end
                8'b00??_?10?: begin     // ALU AL/AX, imm
                    readWide = opcode[0];
                    ipNext   = ip + 16'd1;
                    if (opcode[0] && !step) begin
                        immLowNext = codeData;
                        stepNext   = 1'b1;
                    end else begin
                        regWrite  = '{en: aluReq.op != ALU_CMP, code: REG_AX,
                                      wide: opcode[0], data: aluRes.result};
                        flagsNext = aluRes.flags;
                        stateNext = FETCH;
                    end
                end
                8'b0100_????: begin     // INC/DEC r16
                    readSel     = opcode[2:0];
                    aluReq.op   = opcode[3] ? ALU_SUB : ALU_ADD;
                    aluReq.wide = 1'b1;
                    aluReq.op2  = 16'h0001;
                    regWrite    = '{en: 1'b1, code: opcode[2:0], wide: 1'b1,
                                    data: aluRes.result};
                    flagsNext   = aluRes.flags;
                    stateNext   = FETCH;
                end
                8'b0111_????: begin
                    ipNext    = (condHit ^ opcode[0]) ? ip + 16'd1 + disp : ip + 16'd1;
                    stateNext = FETCH;
                end
                8'hEB: begin
                    ipNext    = ip + 16'd1 + disp;
                    stateNext = FETCH;
                end
                8'b1110_?11?: begin     // OUT imm8 or DX
                    if (!step) begin
                        readSel  = REG_DX;
                        stepNext = 1'b1;
                        if (opcode[3]) begin
                            portAddrNext = readData;
                        end else begin
                            portAddrNext = {8'h00, codeData};
                            ipNext       = ip + 16'd1;
                        end
                    end else begin
                        portReq = 1'b1;         // Data from AX, held until accepted
                        if (portAccept)
                            stateNext = FETCH;
                    end
                end
                default: stateNext = FETCH;
            endcase
        endcase
    end

    always_ff @(posedge clk25) begin
        if (reset) begin
            state <= FETCH;
            ip    <= `RESET_IP;
            flags <= FLAGS_RESET;
            step  <= 1'b0;
        end else begin
            state <= stateNext;
            ip    <= ipNext;
            flags <= flagsNext;
            step  <= stepNext;
        end
    end

    always_ff @(posedge clk25) begin
        immLow   <= immLowNext;
        portAddr <= portAddrNext;
        if (state == FETCH)
            opcode <= codeData;
    end

endmodule

// File: include/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Datapath widths
`define WORD_W       16
`define BYTE_W       8
`define FLAGS_W      12
`define REG_CODE_W   3

// Start address after reset
`define RESET_IP     16'hFFF0

// Port flow control
`define PORT_CREDITS 4
`define CREDIT_W     3     // Holds 0..PORT_CREDITS

`endif

// File: sources.f
+incdir+include
hdl/cpuIsaPkg.sv
hdl/cpuCorePkg.sv
hdl/registerFile.sv
hdl/aluUnit.sv
hdl/sequencer.sv
hdl/portWriter.sv
hdl/cpuTop.sv
tb/cpuTop_checker.sv
tb/cpuTop_tb.sv

// File: tb/cpuTop_checker.sv
`timescale 1ns/1ns
`include "cpu_config.svh"

module cpuTop_checker (
    input logic                 clk25,
    input logic                 reset,
    input logic [`CREDIT_W-1:0] credits,
    input logic                 portAccept,
    input logic                 portClk
);

    // Count never grows past the consumer buffer
    creditBound: assert property (@(posedge clk25) disable iff (reset)
        credits <= `CREDIT_W'(`PORT_CREDITS))
        else $error("credit count above the configured depth");

    strobeAfterAccept: assert property (@(posedge clk25) disable iff (reset)
        portClk |-> $past(portAccept))
        else $error("portClk high without an accept in the cycle before");

    resetClearsStrobe: assert property (@(posedge clk25) reset |=> !portClk)
        else $error("portClk high in the cycle after reset");   // Strobe must clear

endmodule

// File: tb/cpuTop_tb.sv
`timescale 1ns/1ns
`include "cpu_config.svh"

module cpuTop_tb
    import cpuIsaPkg::*, cpuCorePkg::*;
();

    logic      clk25;
    logic      reset;
    wordT      codeAddr;
    byteT      codeData;
    portWriteT portOut;
    logic      portClk;
    logic      portCredit;

    byteT   rom [64];
    string  progQ [$];          // Code bytes as hex text
    string  expQ [$];           // Port writes as addr:data:wide
    int     delayQ [$];         // 0 draws the delay at random
    bit     midResetQ [$];
    int     dueQ [$];           // Cycles at which credits go back
    int     cycleCount = 0;
    int     cycleLimit = 0;
    int     creditDelay = 1;
    int     writesSeen = 0;
    int     creditsBack = 0;
    bit     spareCredit = 1'b0;
    integer seed = 32'h50b9_e74c;

    cpuTop cpuTop_inst (.clk25, .reset, .codeAddr, .codeData, .portOut, .portClk, .portCredit);

    bind portWriter cpuTop_checker checkerInst (.clk25, .reset, .credits, .portAccept, .portClk);

    // ROM index 0 sits at the reset address, wraps past FFFF
    assign codeData = rom[6'(codeAddr - `RESET_IP)];

    initial begin
        clk25 = 1'b0;
        forever #5 clk25 = ~clk25;
    end

    always @(posedge clk25) begin
        cycleCount++;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            $display("timeout: the programs did not finish within %0d cycles", cycleLimit);
            $display("tests failed");
            $fatal(1, "cycle limit reached");
        end
    end

    // ------------------------------
    // Helpers
    task automatic checkValue(input string what, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
            $display("tests failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    function automatic void addRow(input string prog, input string writes, input int delay,
                                   input bit midReset);
        progQ.push_back(prog);
        expQ.push_back(writes);
        delayQ.push_back(delay);
        midResetQ.push_back(midReset);
    endfunction

    function automatic portWriteT parseWrite(input string text, input int k);
        portWriteT w;
        w.addr = wordT'(text.substr(12 * k, 12 * k + 3).atohex());
        w.data = wordT'(text.substr(12 * k + 5, 12 * k + 8).atohex());
        w.wide = text.substr(12 * k + 10, 12 * k + 10) == "1";
        return w;
    endfunction

    function automatic int returnDelay();
        if (creditDelay > 0)
            return creditDelay;
        return 11 + int'($unsigned($random(seed)) % 10);   // Outlasts four OUTs
    endfunction

    task automatic loadProgram(input string text);
        int len;
        int i;
        len = (text.len() + 1) / 3;
        for (i = 0; i < 64; i++) begin
            if (i < len)
                rom[i] = byteT'(text.substr(3 * i, 3 * i + 1).atohex());
            else
                rom[i] = byteT'(i * 37) ^ 8'h5A;    // Never reached
        end
    endtask

    task automatic holdReset();
        reset = 1'b1;
        repeat (5) @(posedge clk25);
        #1;
        reset = 1'b0;
    endtask

    task automatic waitForWrite();
        do @(negedge clk25); while (!portClk);
    endtask

    task automatic runRow(input int row);
        int        total;
        int        w;
        bit        restarted;
        portWriteT want;
        total       = (expQ[row].len() + 1) / 12;
        creditDelay = delayQ[row];
        restarted   = 1'b0;
        @(posedge clk25);
        #1;
        loadProgram(progQ[row]);
        holdReset();
        w = 0;
        while (w < total) begin
            waitForWrite();
            want = parseWrite(expQ[row], w);
            checkValue($sformatf("row %0d write %0d address", row, w), 32'(portOut.addr),
                       32'(want.addr));
            checkValue($sformatf("row %0d write %0d data", row, w), 32'(portOut.data),
                       32'(want.data));
            checkValue($sformatf("row %0d write %0d wide", row, w), 32'(portOut.wide),
                       32'(want.wide));
            w++;
            if (midResetQ[row] && !restarted) begin
                @(posedge clk25);
                #1;
                holdReset();    // Program has not reached its second OUT yet
                restarted = 1'b1;
                w = 0;
            end
        end
    endtask

    // ------------------------------
    // Credit return, one pulse per write after its delay
    initial begin
        portCredit = 1'b0;
        forever begin
            @(negedge clk25);
            if (reset) begin
                dueQ.delete();
                writesSeen = 0;
                creditsBack = 0;
                spareCredit = 1'b1;
            end else if (portClk) begin
                writesSeen++;
                dueQ.push_back(cycleCount + returnDelay());
                checkValue("port writes outstanding within credit depth",
                           32'(writesSeen - creditsBack <= `PORT_CREDITS), 32'd1);
            end
            @(posedge clk25);
            #1;
            portCredit = 1'b0;
            if (!reset && dueQ.size() > 0 && dueQ[0] <= cycleCount) begin
                portCredit = 1'b1;
                void'(dueQ.pop_front());
                creditsBack++;
            end else if (!reset && spareCredit) begin
                portCredit  = 1'b1;     // Surplus pulse while the count is still full
                spareCredit = 1'b0;
            end
        end
    end

    initial begin
        string burst;
        int    row;
        reset = 1'b1;
        // Register moves and byte views
        addRow("B8 34 12 BA 40 00 EF B4 56 EE E7 21 E6 22 EB FE",
               "0040:1234:1 0040:0034:0 0021:5634:1 0022:0034:0", 1, 1'b0);
        addRow("2C 20 14 05 04 30 1C 06 3C 0F E6 01 24 3C 34 F0 0D 00 A5 E7 02 EB FE",
               "0001:000F:0 0002:A5FC:1", 2, 1'b0);
        // Jcc over a two-byte OUT, a write means not taken
        addRow("F9 72 02 E6 10 73 02 E6 11 F5 72 02 E6 12 76 02 E6 13 EB FE",
               "0011:0000:0 0012:0000:0 0013:0000:0", 1, 1'b0);
        addRow("2C 80 70 02 E6 20 79 02 E6 21 7B 02 E6 22 7C 02 E6 23 7F 02 E6 24 EB FE",
               "0021:0080:0 0023:0080:0", 1, 1'b0);
        addRow("3C 00 71 02 E6 30 75 02 E6 31 77 02 E6 32 7A 02 E6 33 7E 02 E6 34 EB FE",
               "0031:0000:0 0032:0000:0", 1, 1'b0);
        // Five passes of DEC CX / JNZ, then DEC from zero sets CF
        addRow("B9 05 00 40 49 75 FC E7 40 49 72 02 E6 41 73 02 E6 42 EB FE",
               "0040:0005:1 0042:0005:0", 2, 1'b0);
        burst = "0050:ABCD:1 0051:ABCD:1 0052:00CD:0 0053:ABCD:1 ";
        burst = {burst, "0054:00CD:0 0055:ABCD:1 0056:00CD:0 0057:ABCD:1"};
        addRow("B8 CD AB E7 50 E7 51 E6 52 E7 53 E6 54 E7 55 E6 56 E7 57 EB FE",
               burst, 0, 1'b0);
        addRow("B8 11 11 E7 60 B9 0A 00 49 75 FD E7 61 EB FE",
               "0060:1111:1 0061:1111:1", 3, 1'b1);
        cycleLimit = progQ.size() * 200;
        loadProgram(progQ[0]);
        for (row = 0; row < progQ.size(); row++)
            runRow(row);
        $display("all tests passed");
        $finish;
    end

endmodule
